//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_noc_fabric
FILELIST  := noc_fabric.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@$(MAKE) --no-print-directory check

check:
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/init_port.sv
`timescale 1ns/100ps
`include "noc_fabric_config.svh"

module init_port (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`NOC_ADDR_W-1:0]   base_addr,
  input  noc_fabric_pkg::noc_req_t req,
  input  logic                     req_valid,
  output logic                     req_ready,
  output noc_fabric_pkg::noc_req_t fwd_req,
  output logic [`NOC_N_TARG-1:0]   fwd_valid,
  input  logic [`NOC_N_TARG-1:0]   fwd_ready,
  output noc_fabric_pkg::noc_rsp_t err_rsp,
  output logic                     err_valid,
  input  logic                     err_ready
);
  import noc_fabric_pkg::*;

  localparam int unsigned TIDX_W = $clog2(`NOC_N_TARG);
  // Bytes covered by all target windows
  localparam logic [`NOC_ADDR_W-1:0] SPAN = `NOC_ADDR_W'(`NOC_N_TARG) << `NOC_WIN_BITS;

  noc_req_t               s_req;
  logic                   s_valid;
  logic                   s_ready;
  logic [`NOC_ADDR_W-1:0] offset;
  logic [TIDX_W-1:0]      tidx;
  logic                   hit;
  logic [`NOC_N_TARG-1:0] tsel;
  logic                   err_free;
  logic                   err_take;
  noc_rsp_t               err_q;
  logic                   err_vld_q;

  // ============================================================
  // Input slice
  // ============================================================
  reg_slice #(.payload_t(noc_req_t)) u_req_slice (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (req),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .out_data  (s_req),
    .out_valid (s_valid),
    .out_ready (s_ready)
  );

  // ============================================================
  // Address decode
  // ============================================================
  assign offset = s_req.addr - base_addr;
  // Below base wraps to a large offset and misses too
  assign hit    = offset < SPAN;
  assign tidx   = offset[`NOC_WIN_BITS +: TIDX_W];

  // One-hot target select
  always_comb begin
    for (int t = 0; t < `NOC_N_TARG; t++) begin
      tsel[t] = hit && (tidx == TIDX_W'(t));
    end
  end

  assign fwd_req   = s_req;
  assign fwd_valid = tsel & {`NOC_N_TARG{s_valid}};

  // Error register free, or emptying this cycle
  assign err_free = ~err_vld_q | err_ready;
  assign err_take = s_valid & ~hit & err_free;
  assign s_ready  = hit ? |(fwd_ready & tsel) : err_free;

  // ============================================================
  // Decode-error response
  // ============================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_vld_q <= 1'b0;
    end else if (err_take) begin
      err_vld_q <= 1'b1;
    end else if (err_ready) begin
      err_vld_q <= 1'b0;
    end
  end

  // Zero data, original id
  always_ff @(posedge clk) begin
    if (err_take) begin
      err_q.rdata <= '0;
      err_q.id    <= s_req.id;
      err_q.err   <= 1'b1;
    end
  end

  assign err_rsp   = err_q;
  assign err_valid = err_vld_q;

  // Never more than one target asked
  a_fwd_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(fwd_valid));

endmodule

//--- design/noc_fabric.sv
`timescale 1ns/100ps
`include "noc_fabric_config.svh"

module noc_fabric (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [`NOC_ADDR_W-1:0]    base_addr,
  // Initiator side
  input  noc_fabric_pkg::noc_req_t  init_req [`NOC_N_INIT],
  input  logic [`NOC_N_INIT-1:0]    init_req_valid,
  output logic [`NOC_N_INIT-1:0]    init_req_ready,
  output noc_fabric_pkg::noc_rsp_t  init_rsp [`NOC_N_INIT],
  output logic [`NOC_N_INIT-1:0]    init_rsp_valid,
  input  logic [`NOC_N_INIT-1:0]    init_rsp_ready,
  // Target side
  output noc_fabric_pkg::noc_treq_t targ_req [`NOC_N_TARG],
  output logic [`NOC_N_TARG-1:0]    targ_req_valid,
  input  logic [`NOC_N_TARG-1:0]    targ_req_ready,
  input  noc_fabric_pkg::noc_trsp_t targ_rsp [`NOC_N_TARG],
  input  logic [`NOC_N_TARG-1:0]    targ_rsp_valid,
  output logic [`NOC_N_TARG-1:0]    targ_rsp_ready
);
  import noc_fabric_pkg::*;

  // Request crossing, initiator by target
  noc_req_t                                fwd_req [`NOC_N_INIT];
  logic [`NOC_N_INIT-1:0][`NOC_N_TARG-1:0] fwd_valid;
  logic [`NOC_N_INIT-1:0][`NOC_N_TARG-1:0] fwd_ready;
  // Same wires seen target by initiator
  logic [`NOC_N_TARG-1:0][`NOC_N_INIT-1:0] arb_valid;
  logic [`NOC_N_TARG-1:0][`NOC_N_INIT-1:0] arb_ready;

  // Response crossing, target by initiator
  noc_trsp_t                               arb_rsp [`NOC_N_TARG];
  logic [`NOC_N_TARG-1:0][`NOC_N_INIT-1:0] arb_rsp_valid;
  logic [`NOC_N_TARG-1:0][`NOC_N_INIT-1:0] arb_rsp_ready;
  logic [`NOC_N_INIT-1:0][`NOC_N_TARG-1:0] rtr_valid;
  logic [`NOC_N_INIT-1:0][`NOC_N_TARG-1:0] rtr_ready;

  // Local decode errors
  noc_rsp_t               err_rsp [`NOC_N_INIT];
  logic [`NOC_N_INIT-1:0] err_valid;
  logic [`NOC_N_INIT-1:0] err_ready;

  // ============================================================
  // Transpose between stages
  // ============================================================
  for (genvar i = 0; i < `NOC_N_INIT; i++) begin : g_row
    for (genvar t = 0; t < `NOC_N_TARG; t++) begin : g_col
      assign arb_valid[t][i]     = fwd_valid[i][t];
      assign fwd_ready[i][t]     = arb_ready[t][i];
      assign rtr_valid[i][t]     = arb_rsp_valid[t][i];
      assign arb_rsp_ready[t][i] = rtr_ready[i][t];
    end
  end

  // ============================================================
  // Initiator ports and response routers
  // ============================================================
  for (genvar i = 0; i < `NOC_N_INIT; i++) begin : g_init
    init_port u_init_port (
      .clk       (clk),
      .arst_n    (arst_n),
      .base_addr (base_addr),
      .req       (init_req[i]),
      .req_valid (init_req_valid[i]),
      .req_ready (init_req_ready[i]),
      .fwd_req   (fwd_req[i]),
      .fwd_valid (fwd_valid[i]),
      .fwd_ready (fwd_ready[i]),
      .err_rsp   (err_rsp[i]),
      .err_valid (err_valid[i]),
      .err_ready (err_ready[i])
    );

    resp_router u_resp_router (
      .clk        (clk),
      .arst_n     (arst_n),
      .targ_rsp   (arb_rsp),
      .targ_valid (rtr_valid[i]),
      .targ_ready (rtr_ready[i]),
      .err_rsp    (err_rsp[i]),
      .err_valid  (err_valid[i]),
      .err_ready  (err_ready[i]),
      .rsp        (init_rsp[i]),
      .rsp_valid  (init_rsp_valid[i]),
      .rsp_ready  (init_rsp_ready[i])
    );
  end

  // ============================================================
  // Target arbiters
  // ============================================================
  for (genvar t = 0; t < `NOC_N_TARG; t++) begin : g_targ
    target_arbiter u_target_arbiter (
      .clk            (clk),
      .arst_n         (arst_n),
      .in_req         (fwd_req),
      .in_valid       (arb_valid[t]),
      .in_ready       (arb_ready[t]),
      .targ_req       (targ_req[t]),
      .targ_req_valid (targ_req_valid[t]),
      .targ_req_ready (targ_req_ready[t]),
      .targ_rsp       (targ_rsp[t]),
      .targ_rsp_valid (targ_rsp_valid[t]),
      .targ_rsp_ready (targ_rsp_ready[t]),
      .out_rsp        (arb_rsp[t]),
      .out_rsp_valid  (arb_rsp_valid[t]),
      .out_rsp_ready  (arb_rsp_ready[t])
    );
  end

endmodule

//--- design/noc_fabric_config.svh
`ifndef NOC_FABRIC_CONFIG_SVH
`define NOC_FABRIC_CONFIG_SVH

// ============================================================
// Port counts
// ============================================================
// Initiators on the request side
`define NOC_N_INIT 4
// Targets behind the fabric
`define NOC_N_TARG 3

// ============================================================
// Widths
// ============================================================
`define NOC_ADDR_W 32
`define NOC_DATA_W 32
// Id as seen by an initiator
`define NOC_ID_W 4
// Source index prepended to the id on the target side
`define NOC_SRC_W 2

// Each target window is 2**NOC_WIN_BITS bytes
`define NOC_WIN_BITS 12

`endif

//--- design/noc_fabric_pkg.sv
`include "noc_fabric_config.svh"

package noc_fabric_pkg;

  // Widest request vector the round-robin helper handles
  localparam int unsigned RR_W = 8;

  // ============================================================
  // Transaction types
  // ============================================================
  // Target-side tag, source index in the upper bits
  typedef struct packed {
    logic [`NOC_SRC_W-1:0] src;
    logic [`NOC_ID_W-1:0]  id;
  } noc_tid_t;

  // Initiator-side request
  typedef struct packed {
    logic [`NOC_ADDR_W-1:0] addr;
    logic                   write;
    logic [`NOC_DATA_W-1:0] wdata;
    logic [`NOC_ID_W-1:0]   id;
  } noc_req_t;

  // Initiator-side response
  typedef struct packed {
    logic [`NOC_DATA_W-1:0] rdata;
    logic [`NOC_ID_W-1:0]   id;
    logic                   err;
  } noc_rsp_t;

  // Target-side request, id widened by the source index
  typedef struct packed {
    logic [`NOC_ADDR_W-1:0] addr;
    logic                   write;
    logic [`NOC_DATA_W-1:0] wdata;
    noc_tid_t               tid;
  } noc_treq_t;

  // Target-side response
  typedef struct packed {
    logic [`NOC_DATA_W-1:0] rdata;
    noc_tid_t               tid;
    logic                   err;
  } noc_trsp_t;

  // ============================================================
  // Round-robin pick
  // ============================================================
  // First requester after last, wrapping over n
  function automatic int unsigned rr_next(
    input logic [RR_W-1:0] req,
    input int unsigned     last,
    input int unsigned     n
  );
    int unsigned idx;
    int unsigned pick;
    pick = last;
    // Walk down so the nearest requester wins
    for (int k = RR_W; k > 0; k--) begin
      if (k <= n) begin
        idx = (last + k) % n;
        if (req[idx]) begin
          pick = idx;
        end
      end
    end
    return pick;
  endfunction

endpackage

//--- design/reg_slice.sv
`timescale 1ns/100ps

module reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // ============================================================
  // Storage
  // ============================================================
  // Main entry drives the output
  payload_t main_q;
  // Skid entry catches the beat in flight on a stall
  payload_t skid_q;
  logic     main_vld_q;
  logic     skid_vld_q;
  // Registered ready, low out of reset
  logic     rdy_q;

  logic push;
  logic pop;
  logic main_vld_d;
  logic skid_vld_d;
  logic load_in;
  logic load_skid;
  logic spill;

  assign push = in_valid & rdy_q;
  assign pop  = main_vld_q & out_ready;

  // Next-state of the two entries
  always_comb begin
    main_vld_d = main_vld_q;
    skid_vld_d = skid_vld_q;
    load_in    = 1'b0;
    load_skid  = 1'b0;
    spill      = 1'b0;
    if (pop && skid_vld_q) begin
      // Skid beat moves up, no push possible here
      load_skid  = 1'b1;
      skid_vld_d = 1'b0;
    end else if (pop || !main_vld_q) begin
      // Main free or draining
      load_in    = push;
      main_vld_d = push;
    end else if (push) begin
      // Output stalled, park the new beat
      spill      = 1'b1;
      skid_vld_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_vld_q <= 1'b0;
      skid_vld_q <= 1'b0;
      rdy_q      <= 1'b0;
    end else begin
      main_vld_q <= main_vld_d;
      skid_vld_q <= skid_vld_d;
      rdy_q      <= ~skid_vld_d;
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (load_in) begin
      main_q <= in_data;
    end else if (load_skid) begin
      main_q <= skid_q;
    end
    if (spill) begin
      skid_q <= in_data;
    end
  end

  assign in_ready  = rdy_q;
  assign out_valid = main_vld_q;
  assign out_data  = main_q;

  // Stalled output keeps its beat
  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- design/resp_router.sv
`timescale 1ns/100ps
`include "noc_fabric_config.svh"

module resp_router (
  input  logic                      clk,
  input  logic                      arst_n,
  input  noc_fabric_pkg::noc_trsp_t targ_rsp [`NOC_N_TARG],
  input  logic [`NOC_N_TARG-1:0]    targ_valid,
  output logic [`NOC_N_TARG-1:0]    targ_ready,
  input  noc_fabric_pkg::noc_rsp_t  err_rsp,
  input  logic                      err_valid,
  output logic                      err_ready,
  output noc_fabric_pkg::noc_rsp_t  rsp,
  output logic                      rsp_valid,
  input  logic                      rsp_ready
);
  import noc_fabric_pkg::*;

  // Targets first, local decode error last
  localparam int unsigned N_SRC = `NOC_N_TARG + 1;
  localparam int unsigned SEL_W = $clog2(N_SRC);

  noc_rsp_t         src_rsp [N_SRC];
  logic [N_SRC-1:0] src_valid;
  logic [N_SRC-1:0] gnt;
  logic [SEL_W-1:0] ptr_q;
  logic [SEL_W-1:0] sel;
  logic             any_vld;
  logic             s_ready;

  // ============================================================
  // Source merge
  // ============================================================
  // Strip the source index
  always_comb begin
    for (int t = 0; t < `NOC_N_TARG; t++) begin
      src_rsp[t].rdata = targ_rsp[t].rdata;
      src_rsp[t].id    = targ_rsp[t].tid.id;
      src_rsp[t].err   = targ_rsp[t].err;
    end
    src_rsp[`NOC_N_TARG] = err_rsp;
  end

  assign src_valid = {err_valid, targ_valid};
  assign any_vld   = |src_valid;
  assign sel       = SEL_W'(rr_next(RR_W'(src_valid), int'(ptr_q), N_SRC));

  always_comb begin
    for (int s = 0; s < N_SRC; s++) begin
      gnt[s] = any_vld && (sel == SEL_W'(s));
    end
  end

  assign targ_ready = gnt[`NOC_N_TARG-1:0] & {`NOC_N_TARG{s_ready}};
  assign err_ready  = gnt[`NOC_N_TARG] & s_ready;

  // Rotate past the source just taken
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr_q <= SEL_W'(N_SRC - 1);
    end else if (any_vld && s_ready) begin
      ptr_q <= sel;
    end
  end

  // ============================================================
  // Output slice
  // ============================================================
  reg_slice #(.payload_t(noc_rsp_t)) u_rsp_slice (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (src_rsp[sel]),
    .in_valid  (any_vld),
    .in_ready  (s_ready),
    .out_data  (rsp),
    .out_valid (rsp_valid),
    .out_ready (rsp_ready)
  );

endmodule

//--- design/target_arbiter.sv
`timescale 1ns/100ps
`include "noc_fabric_config.svh"

module target_arbiter (
  input  logic                      clk,
  input  logic                      arst_n,
  input  noc_fabric_pkg::noc_req_t  in_req [`NOC_N_INIT],
  input  logic [`NOC_N_INIT-1:0]    in_valid,
  output logic [`NOC_N_INIT-1:0]    in_ready,
  output noc_fabric_pkg::noc_treq_t targ_req,
  output logic                      targ_req_valid,
  input  logic                      targ_req_ready,
  input  noc_fabric_pkg::noc_trsp_t targ_rsp,
  input  logic                      targ_rsp_valid,
  output logic                      targ_rsp_ready,
  output noc_fabric_pkg::noc_trsp_t out_rsp,
  output logic [`NOC_N_INIT-1:0]    out_rsp_valid,
  input  logic [`NOC_N_INIT-1:0]    out_rsp_ready
);
  import noc_fabric_pkg::*;

  // Last granted initiator
  logic [`NOC_SRC_W-1:0]  ptr_q;
  logic [`NOC_SRC_W-1:0]  gnt_idx;
  logic [`NOC_N_INIT-1:0] gnt;
  logic                   any_req;
  logic                   s_ready;
  noc_treq_t              treq;

  // ============================================================
  // Request arbitration
  // ============================================================
  assign any_req = |in_valid;
  assign gnt_idx = `NOC_SRC_W'(rr_next(RR_W'(in_valid), int'(ptr_q), `NOC_N_INIT));

  always_comb begin
    for (int i = 0; i < `NOC_N_INIT; i++) begin
      gnt[i] = any_req && (gnt_idx == `NOC_SRC_W'(i));
    end
  end

  // Only the winner sees ready
  assign in_ready = gnt & {`NOC_N_INIT{s_ready}};

  // Pointer moves on an accepted grant only
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr_q <= `NOC_SRC_W'(`NOC_N_INIT - 1);
    end else if (any_req && s_ready) begin
      ptr_q <= gnt_idx;
    end
  end

  // Tag with source index
  always_comb begin
    treq.addr    = in_req[gnt_idx].addr;
    treq.write   = in_req[gnt_idx].write;
    treq.wdata   = in_req[gnt_idx].wdata;
    treq.tid.src = gnt_idx;
    treq.tid.id  = in_req[gnt_idx].id;
  end

  reg_slice #(.payload_t(noc_treq_t)) u_treq_slice (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (treq),
    .in_valid  (any_req),
    .in_ready  (s_ready),
    .out_data  (targ_req),
    .out_valid (targ_req_valid),
    .out_ready (targ_req_ready)
  );

  // ============================================================
  // Response steering
  // ============================================================
  // Payload broadcast, valid to the tagged initiator
  assign out_rsp = targ_rsp;

  always_comb begin
    for (int i = 0; i < `NOC_N_INIT; i++) begin
      out_rsp_valid[i] = targ_rsp_valid && (targ_rsp.tid.src == `NOC_SRC_W'(i));
    end
  end

  // Ready from the addressed router only
  assign targ_rsp_ready = out_rsp_ready[targ_rsp.tid.src];

  // Single winner per accepted transfer
  a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    |(in_valid & in_ready) |-> $onehot(in_valid & in_ready));

endmodule

//--- noc_fabric.f
+incdir+design
design/noc_fabric_pkg.sv
design/reg_slice.sv
design/init_port.sv
design/target_arbiter.sv
design/resp_router.sv
design/noc_fabric.sv
testbench/tb_target_mem.sv
testbench/tb_noc_fabric.sv

//--- testbench/tb_noc_fabric.sv
`timescale 1ns/100ps
`include "noc_fabric_config.svh"

module tb_noc_fabric;
  import noc_fabric_pkg::*;

  localparam int unsigned WAIT_MAX = 400;
  localparam int unsigned N_RAND   = 40;
  localparam logic [31:0] BASE     = 32'h4000_0000;
  localparam logic [31:0] WIN      = 32'h1 << `NOC_WIN_BITS;

  logic                   clk;
  logic                   arst_n;
  logic [`NOC_ADDR_W-1:0] base_addr;
  noc_req_t               init_req [`NOC_N_INIT];
  logic [`NOC_N_INIT-1:0] init_req_valid;
  logic [`NOC_N_INIT-1:0] init_req_ready;
  noc_rsp_t               init_rsp [`NOC_N_INIT];
  logic [`NOC_N_INIT-1:0] init_rsp_valid;
  logic [`NOC_N_INIT-1:0] init_rsp_ready;
  noc_treq_t              targ_req [`NOC_N_TARG];
  logic [`NOC_N_TARG-1:0] targ_req_valid;
  logic [`NOC_N_TARG-1:0] targ_req_ready;
  noc_trsp_t              targ_rsp [`NOC_N_TARG];
  logic [`NOC_N_TARG-1:0] targ_rsp_valid;
  logic [`NOC_N_TARG-1:0] targ_rsp_ready;

  // Scoreboard, one outstanding request per initiator
  logic [31:0]            rng_q;
  logic [31:0]            shadow [logic [31:0]];
  noc_req_t               exp_req [`NOC_N_INIT];
  int                     exp_tgt [`NOC_N_INIT];
  bit                     busy [`NOC_N_INIT];
  bit                     seen [`NOC_N_INIT];
  int                     skip_cnt [`NOC_N_INIT][`NOC_N_INIT];
  logic [`NOC_ID_W-1:0]   next_id [`NOC_N_INIT];

  noc_fabric dut (.*);

  for (genvar t = 0; t < `NOC_N_TARG; t++) begin : g_mem
    tb_target_mem #(.IDX(t)) u_mem (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (targ_req[t]),
      .req_valid (targ_req_valid[t]),
      .req_ready (targ_req_ready[t]),
      .rsp       (targ_rsp[t]),
      .rsp_valid (targ_rsp_valid[t]),
      .rsp_ready (targ_rsp_ready[t])
    );
  end

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ============================================================
  // Helpers
  // ============================================================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_word();
    rng_q = xorshift(rng_q);
    return rng_q;
  endfunction

  // Reference decode, -1 for an unmapped address
  function automatic int expected_target(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - BASE;
    if (off < `NOC_N_TARG * WIN) begin
      return int'(off >> `NOC_WIN_BITS);
    end
    return -1;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_treq(input string name, input noc_treq_t got, input noc_treq_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic check_rsp(input string name, input noc_rsp_t got, input noc_rsp_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic require_idle(input string when);
    if (init_req_ready !== '0 || init_rsp_valid !== '0 ||
        targ_req_valid !== '0 || targ_rsp_ready !== '0) begin
      abort_run($sformatf("A valid or ready output is high %s", when));
    end
  endtask

  // ============================================================
  // One transaction on initiator i
  // ============================================================
  task automatic run_txn(input int i, input logic [31:0] addr, input logic write,
                         input logic [31:0] wdata);
    noc_req_t rq;
    noc_rsp_t exp;
    noc_rsp_t got;
    int       tgt;
    int       n;
    bit       done;
    rq.addr    = addr;
    rq.write   = write;
    rq.wdata   = wdata;
    rq.id      = next_id[i];
    next_id[i] = next_id[i] + 1;
    tgt        = expected_target(addr);
    exp.id     = rq.id;
    exp.err    = (tgt < 0);
    exp.rdata  = '0;
    if (tgt >= 0 && !write) begin
      exp.rdata = shadow[addr];
    end
    if (tgt >= 0 && write) begin
      shadow[addr] = wdata;
    end
    exp_req[i] = rq;
    exp_tgt[i] = tgt;
    seen[i]    = 1'b0;
    busy[i]    = 1'b1;
    for (int r = 0; r < `NOC_N_INIT; r++) begin
      skip_cnt[i][r] = 0;
    end
    @(posedge clk);
    init_req[i]       <= rq;
    init_req_valid[i] <= 1'b1;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (init_req_ready[i]) begin
        done = 1'b1;
      end else begin
        n++;
        if (n > WAIT_MAX) abort_run($sformatf("Initiator %0d request never accepted", i));
      end
    end
    @(posedge clk);
    init_req_valid[i] <= 1'b0;
    // Response side, ready toggles randomly
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      init_rsp_ready[i] <= (next_word() % 4) != 0;
      @(negedge clk);
      if (init_rsp_valid[i] && init_rsp_ready[i]) begin
        got  = init_rsp[i];
        done = 1'b1;
      end else begin
        n++;
        if (n > WAIT_MAX) abort_run($sformatf("Initiator %0d response never arrived", i));
      end
    end
    @(posedge clk);
    init_rsp_ready[i] <= 1'b0;
    busy[i] = 1'b0;
    check_rsp($sformatf("init_rsp[%0d]", i), got, exp);
    if (tgt >= 0 && !seen[i]) begin
      abort_run($sformatf("Initiator %0d got a response but no target saw it", i));
    end
  endtask

  // All initiators hammer target 1 in their own address slots
  task automatic random_traffic(input int i);
    logic [31:0] addr;
    logic        write;
    for (int n = 0; n < N_RAND; n++) begin
      addr  = BASE + WIN + (i << 5) + ((next_word() % 8) << 2);
      write = !shadow.exists(addr) || (next_word() % 2 == 1);
      run_txn(i, addr, write, next_word());
    end
  endtask

  // ============================================================
  // Target-side monitor and fairness
  // ============================================================
  always @(negedge clk) begin : mon
    noc_treq_t exp_t;
    int        s;
    if (arst_n) begin
      for (int t = 0; t < `NOC_N_TARG; t++) begin
        if (targ_req_valid[t] && targ_req_ready[t]) begin
          s = int'(targ_req[t].tid.src);
          if (!busy[s] || seen[s]) begin
            abort_run($sformatf("Unexpected or repeated request from %0d at target %0d", s, t));
          end
          if (exp_tgt[s] != t) begin
            abort_run($sformatf("Initiator %0d request reached target %0d, expected %0d",
                                s, t, exp_tgt[s]));
          end
          exp_t.addr    = exp_req[s].addr;
          exp_t.write   = exp_req[s].write;
          exp_t.wdata   = exp_req[s].wdata;
          exp_t.tid.src = `NOC_SRC_W'(s);
          exp_t.tid.id  = exp_req[s].id;
          check_treq($sformatf("targ_req[%0d]", t), targ_req[t], exp_t);
          for (int r = 0; r < `NOC_N_INIT; r++) begin
            if (r != s && busy[r] && !seen[r] && exp_tgt[r] == t) begin
              skip_cnt[r][s]++;
              if (skip_cnt[r][s] > 1) begin
                abort_run($sformatf("Initiator %0d passed over twice by %0d", r, s));
              end
            end
          end
          seen[s] = 1'b1;
        end
      end
      for (int i = 0; i < `NOC_N_INIT; i++) begin
        if (init_rsp_valid[i] && !busy[i]) begin
          abort_run($sformatf("Response on initiator %0d with nothing outstanding", i));
        end
      end
    end
  end

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    rng_q          = 32'd65866;
    base_addr      = BASE;
    arst_n         = 1'b0;
    init_req_valid = '0;
    init_rsp_ready = '0;
    for (int i = 0; i < `NOC_N_INIT; i++) begin
      init_req[i] = '0;
      next_id[i]  = '0;
      busy[i]     = 1'b0;
      seen[i]     = 1'b0;
      exp_tgt[i]  = -1;
    end
    repeat (2) begin
      @(negedge clk);
      require_idle("during reset");
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    require_idle("in the first cycle after reset");

    // Routing and read-after-write across initiators
    for (int t = 0; t < `NOC_N_TARG; t++) begin
      run_txn(0, BASE + t * WIN + 32'h800, 1'b1, 32'hC0DE_0000 + t);
      run_txn(3, BASE + t * WIN + 32'h800, 1'b0, '0);
      run_txn(2, BASE + t * WIN + 32'h800, 1'b1, next_word());
      run_txn(1, BASE + t * WIN + 32'h800, 1'b0, '0);
    end

    // Unmapped addresses above, below and far away
    run_txn(1, BASE + `NOC_N_TARG * WIN, 1'b1, 32'hDEAD_BEEF);
    run_txn(2, BASE - 4, 1'b0, '0);
    run_txn(0, 32'hFFFF_FFF0, 1'b0, '0);

    // Contention on one target
    fork
      random_traffic(0);
      random_traffic(1);
      random_traffic(2);
      random_traffic(3);
    join

    repeat (5) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- testbench/tb_target_mem.sv
`timescale 1ns/100ps
`include "noc_fabric_config.svh"

module tb_target_mem #(
  parameter int unsigned IDX = 0
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  noc_fabric_pkg::noc_treq_t req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output noc_fabric_pkg::noc_trsp_t rsp,
  output logic                      rsp_valid,
  input  logic                      rsp_ready
);
  import noc_fabric_pkg::*;

  localparam int unsigned DEPTH = 1 << (`NOC_WIN_BITS - 2);

  logic [`NOC_DATA_W-1:0] mem [DEPTH];
  logic [31:0]            rng_q;
  logic                   busy;
  logic [1:0]             delay;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Fill from the whole word index
  initial begin
    rng_q = 32'd65866 + IDX;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'hA5A5_0000 ^ (i * 32'h0001_9E37) ^ IDX;
    end
  end

  // ============================================================
  // One request at a time, random ready and delay
  // ============================================================
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_ready <= 1'b0;
      rsp_valid <= 1'b0;
      busy      <= 1'b0;
      delay     <= '0;
    end else begin
      rng_q <= xorshift(rng_q);
      if (!busy) begin
        if (req_valid && req_ready) begin
          if (req.write) begin
            mem[req.addr[`NOC_WIN_BITS-1:2]] <= req.wdata;
          end
          // Writes answer with zero data
          rsp.rdata <= req.write ? '0 : mem[req.addr[`NOC_WIN_BITS-1:2]];
          rsp.tid   <= req.tid;
          rsp.err   <= 1'b0;
          busy      <= 1'b1;
          req_ready <= 1'b0;
          delay     <= rng_q[5:4];
        end else begin
          req_ready <= rng_q[0];
        end
      end else if (!rsp_valid) begin
        if (delay == 0) begin
          rsp_valid <= 1'b1;
        end else begin
          delay <= delay - 1;
        end
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
        busy      <= 1'b0;
      end
    end
  end

endmodule
